// ==== design/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

  // Base and atomic major opcodes
  localparam logic [6:0] load_op   = 7'b0000011;
  localparam logic [6:0] store_op  = 7'b0100011;
  localparam logic [6:0] imm_op    = 7'b0010011;
  localparam logic [6:0] reg_op    = 7'b0110011;
  localparam logic [6:0] branch_op = 7'b1100011;
  localparam logic [6:0] jal_op    = 7'b1101111;
  localparam logic [6:0] jalr_op   = 7'b1100111;
  localparam logic [6:0] atomic_op = 7'b0101111;

  localparam logic [4:0] alu_add_op = 5'b00000;

  // Codes 0 to 7 carry funct3 of a conditional branch
  localparam logic [3:0] branch_jal  = 4'b1000;
  localparam logic [3:0] branch_jalr = 4'b1001;
  localparam logic [3:0] branch_none = 4'b1111;

  localparam logic [4:0] atomic_no_op = 5'b11111; // Not a valid AMO funct5

  // A fetch word seen as one instruction or as two halfwords
  typedef union packed {
    logic [31:0]      full;
    logic [1:0][15:0] half; // Index 0 is the low half
  } fetch_word_t;

endpackage

`default_nettype wire

// ==== design/flow_pkg.sv ====
`default_nettype none

package flow_pkg;

  localparam int unsigned buffer_depth = 4;

  // Pointers wrap on their own since the depth is a power of two
  localparam int unsigned ptr_width = 2;

  // Counts 0 to buffer_depth inclusive
  localparam int unsigned credit_width = 3;

endpackage

`default_nettype wire

// ==== design/fetch_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_unit
  import rv_isa_pkg::*, flow_pkg::*;
(
  input  wire               clk,
  input  wire               reset,
  input  wire               fetch_valid,
  input  fetch_word_t       fetch_word,
  output logic              fetch_ready,
  output logic              push,
  output logic [31:0]       push_instr,
  input  wire               credit_return
);

  logic [credit_width-1:0] credits;
  logic                    pending;
  logic [15:0]             pending_half;
  logic                    accept;
  logic                    spend;

  // A pending high half blocks new words until it has been pushed
  assign fetch_ready = !pending && (credits != '0);
  assign accept = fetch_valid && fetch_ready;
  assign spend = (pending || accept) && (credits != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= credit_width'(buffer_depth);
      pending <= 1'b0;
      push <= 1'b0;
    end else begin
      credits <= credits - credit_width'(spend) + credit_width'(credit_return);
      push <= spend;
      if (pending && spend) begin
        pending <= 1'b0;
      end else if (accept && fetch_word.half[0][1:0] != 2'b11) begin
        pending <= (fetch_word.half[1] != 16'h0000); // Zero upper half is padding
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pending) begin
      if (spend) push_instr <= {16'h0000, pending_half};
    end else if (accept) begin
      if (fetch_word.half[0][1:0] == 2'b11) begin
        push_instr <= fetch_word.full;
      end else begin
        push_instr <= {16'h0000, fetch_word.half[0]};
        pending_half <= fetch_word.half[1];
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/instr_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module instr_buffer
  import flow_pkg::*;
(
  input  wire         clk,
  input  wire         reset,
  input  wire         push,
  input  wire  [31:0] push_instr,
  output logic        head_valid,
  output logic [31:0] head_instr,
  input  wire         pop,
  output logic        credit_return
);

  logic [31:0]             mem [0:buffer_depth-1];
  logic [ptr_width-1:0]    wr_ptr;
  logic [ptr_width-1:0]    rd_ptr;
  logic [credit_width-1:0] count;

  assign head_valid = (count != '0);
  assign head_instr = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      credit_return <= 1'b0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
      // One credit goes back for every entry freed
      credit_return <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= push_instr;
  end

endmodule

`default_nettype wire

// ==== design/decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module decoder
  import rv_isa_pkg::*;
(
  input  wire  [31:0] instruction,
  output logic [4:0]  rs1,
  output logic [4:0]  rs2,
  output logic [4:0]  rd,
  output logic [31:0] immediate,
  output logic        alu_use_rs2,
  output logic [4:0]  alu_op,
  output logic        reg_write,
  output logic        mem_write,
  output logic        mem_read,
  output logic [2:0]  mem_op_length,
  output logic [3:0]  branch_type,
  output logic [4:0]  atomic_op,
  output logic        is_compact
);

  logic [2:0] funct3;
  logic [6:0] opcode;

  assign funct3 = instruction[14:12];
  assign opcode = instruction[6:0];
  assign is_compact = (opcode[1:0] != 2'b11) && (instruction != 32'h0000_0000);
  assign mem_op_length = funct3;

  always_comb begin
    if (!is_compact) begin
      rs1 = instruction[19:15];
      rs2 = instruction[24:20];
      rd = instruction[11:7];
      reg_write = (opcode == load_op) || (opcode == reg_op) || (opcode == imm_op) ||
                  (opcode == rv_isa_pkg::atomic_op) || (opcode == jalr_op) ||
                  (opcode == jal_op);
      mem_read = (opcode == load_op) || (opcode == rv_isa_pkg::atomic_op);
      mem_write = (opcode == store_op) || (opcode == rv_isa_pkg::atomic_op);
      alu_use_rs2 = (opcode == reg_op);

      if (opcode == load_op || opcode == store_op || opcode == rv_isa_pkg::atomic_op) begin
        alu_op = alu_add_op; // Address is base plus offset
      end else if (opcode == imm_op && funct3 != 3'b101) begin
        alu_op = {2'b00, funct3};
      end else begin
        alu_op = {instruction[25], instruction[30], funct3};
      end

      if (opcode == imm_op && funct3 == 3'b101) begin
        immediate = {27'd0, instruction[24:20]}; // Shift amount only
      end else if (opcode == store_op) begin
        immediate = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
      end else if (opcode == branch_op) begin
        immediate = {{19{instruction[31]}}, instruction[31], instruction[7],
                     instruction[30:25], instruction[11:8], 1'b0};
      end else if (opcode == rv_isa_pkg::atomic_op) begin
        immediate = 32'd0;
      end else if (opcode == jal_op) begin
        immediate = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                     instruction[20], instruction[30:21], 1'b0};
      end else begin
        immediate = {{20{instruction[31]}}, instruction[31:20]};
      end

      if (opcode == branch_op) begin
        branch_type = {1'b0, funct3};
      end else if (opcode == jal_op) begin
        branch_type = branch_jal;
      end else if (opcode == jalr_op) begin
        branch_type = branch_jalr;
      end else begin
        branch_type = branch_none;
      end

      atomic_op = (opcode == rv_isa_pkg::atomic_op) ? instruction[31:27] : atomic_no_op;
    end else begin
      // Every compact instruction is treated as rd = rs1 + rs2
      rs1 = instruction[11:7];
      rs2 = instruction[6:2];
      rd = instruction[11:7];
      reg_write = 1'b1;
      mem_read = 1'b0;
      mem_write = 1'b0;
      alu_use_rs2 = 1'b1;
      alu_op = alu_add_op;
      immediate = 32'd0;
      branch_type = branch_none;
      atomic_op = atomic_no_op;
    end
  end

endmodule

`default_nettype wire

// ==== design/decode_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
  input  wire         clk,
  input  wire         reset,
  input  wire         head_valid,
  input  wire  [31:0] head_instr,
  output logic        pop,
  output logic        out_valid,
  input  wire         out_ready,
  output logic [4:0]  rs1,
  output logic [4:0]  rs2,
  output logic [4:0]  rd,
  output logic [31:0] immediate,
  output logic        alu_use_rs2,
  output logic [4:0]  alu_op,
  output logic        reg_write,
  output logic        mem_write,
  output logic        mem_read,
  output logic [2:0]  mem_op_length,
  output logic [3:0]  branch_type,
  output logic [4:0]  atomic_op,
  output logic        is_compact
);

  logic [4:0]  dec_rs1;
  logic [4:0]  dec_rs2;
  logic [4:0]  dec_rd;
  logic [31:0] dec_immediate;
  logic        dec_alu_use_rs2;
  logic [4:0]  dec_alu_op;
  logic        dec_reg_write;
  logic        dec_mem_write;
  logic        dec_mem_read;
  logic [2:0]  dec_mem_op_length;
  logic [3:0]  dec_branch_type;
  logic [4:0]  dec_atomic_op;
  logic        dec_is_compact;

  decoder u_decoder (
    .instruction  (head_instr),
    .rs1          (dec_rs1),
    .rs2          (dec_rs2),
    .rd           (dec_rd),
    .immediate    (dec_immediate),
    .alu_use_rs2  (dec_alu_use_rs2),
    .alu_op       (dec_alu_op),
    .reg_write    (dec_reg_write),
    .mem_write    (dec_mem_write),
    .mem_read     (dec_mem_read),
    .mem_op_length(dec_mem_op_length),
    .branch_type  (dec_branch_type),
    .atomic_op    (dec_atomic_op),
    .is_compact   (dec_is_compact)
  );

  // Output slot is free, or its result leaves on this edge
  assign pop = head_valid && (!out_valid || out_ready);

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (pop) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      rs1 <= dec_rs1;
      rs2 <= dec_rs2;
      rd <= dec_rd;
      immediate <= dec_immediate;
      alu_use_rs2 <= dec_alu_use_rs2;
      alu_op <= dec_alu_op;
      reg_write <= dec_reg_write;
      mem_write <= dec_mem_write;
      mem_read <= dec_mem_read;
      mem_op_length <= dec_mem_op_length;
      branch_type <= dec_branch_type;
      atomic_op <= dec_atomic_op;
      is_compact <= dec_is_compact;
    end
  end

endmodule

`default_nettype wire

// ==== design/decode_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_top
  import rv_isa_pkg::*;
(
  input  wire         clk,
  input  wire         reset,
  input  wire         fetch_valid,
  input  fetch_word_t fetch_word,
  output logic        fetch_ready,
  input  wire         out_ready,
  output logic        out_valid,
  output logic [4:0]  rs1,
  output logic [4:0]  rs2,
  output logic [4:0]  rd,
  output logic [31:0] immediate,
  output logic        alu_use_rs2,
  output logic [4:0]  alu_op,
  output logic        reg_write,
  output logic        mem_write,
  output logic        mem_read,
  output logic [2:0]  mem_op_length,
  output logic [3:0]  branch_type,
  output logic [4:0]  atomic_op,
  output logic        is_compact
);

  logic        push;
  logic [31:0] push_instr;
  logic        credit_return;
  logic        head_valid;
  logic [31:0] head_instr;
  logic        pop;

  fetch_unit u_fetch_unit (
    .clk          (clk),
    .reset        (reset),
    .fetch_valid  (fetch_valid),
    .fetch_word   (fetch_word),
    .fetch_ready  (fetch_ready),
    .push         (push),
    .push_instr   (push_instr),
    .credit_return(credit_return)
  );

  instr_buffer u_instr_buffer (
    .clk          (clk),
    .reset        (reset),
    .push         (push),
    .push_instr   (push_instr),
    .head_valid   (head_valid),
    .head_instr   (head_instr),
    .pop          (pop),
    .credit_return(credit_return)
  );

  decode_stage u_decode_stage (
    .clk          (clk),
    .reset        (reset),
    .head_valid   (head_valid),
    .head_instr   (head_instr),
    .pop          (pop),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .rs1          (rs1),
    .rs2          (rs2),
    .rd           (rd),
    .immediate    (immediate),
    .alu_use_rs2  (alu_use_rs2),
    .alu_op       (alu_op),
    .reg_write    (reg_write),
    .mem_write    (mem_write),
    .mem_read     (mem_read),
    .mem_op_length(mem_op_length),
    .branch_type  (branch_type),
    .atomic_op    (atomic_op),
    .is_compact   (is_compact)
  );

endmodule

`default_nettype wire

// ==== tests/decode_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

// Level checks shared by the credit counter and the buffer occupancy
module decode_properties
  import flow_pkg::*;
(
  input wire                    clk,
  input wire                    reset,
  input wire                    drain, // Needs a nonzero level
  input wire                    fill,  // Needs room below buffer_depth
  input wire [credit_width-1:0] level
);

  a_drain_nonzero: assert property (@(posedge clk) disable iff (reset) drain |-> level != '0)
    else $error("Level is zero on a push or pop that needs it");

  a_fill_room: assert property (@(posedge clk) disable iff (reset)
    fill |-> level < credit_width'(buffer_depth))
    else $error("Level already at buffer depth on a push or a credit return");

  a_level_range: assert property (@(posedge clk) disable iff (reset)
    level <= credit_width'(buffer_depth))
    else $error("Level above buffer depth");

endmodule

bind fetch_unit decode_properties credit_props (
  .clk(clk), .reset(reset), .drain(spend), .fill(credit_return), .level(credits)
);
bind instr_buffer decode_properties fill_props (
  .clk(clk), .reset(reset), .drain(pop), .fill(push), .level(count)
);

`default_nettype wire

// ==== tests/tb_decode_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_decode_top
  import rv_isa_pkg::*, flow_pkg::*;
();

  localparam int half_period = 20;
  localparam int directed_count = 15;
  localparam int compact_count = 4;
  localparam int random_count = 200;
  localparam int timeout_cycles =
    40 * (directed_count + compact_count + 2 * random_count) + 200;

  localparam logic [31:0] directed_words [directed_count] = '{
    32'h00a00093, 32'hfff14113, 32'h00509193, 32'h4030d213, 32'h002081b3,
    32'h40208233, 32'h0220c2b3, 32'h0080a303, 32'hfe112e23, 32'hfe208ee3,
    32'h0000c463, 32'h800000ef, 32'h008100e7, 32'h0820a2af, 32'h1000a1af
  };
  // Two compact halves, or one with a zero upper half
  localparam logic [31:0] compact_words [compact_count] = '{
    32'h9086_4501, 32'h0000_8082, 32'h0405_1141, 32'h0000_0001
  };
  localparam logic [6:0] class_ops [8] = '{
    load_op, store_op, imm_op, reg_op, branch_op, jal_op, jalr_op, rv_isa_pkg::atomic_op
  };

  typedef struct packed {
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] immediate;
    logic        alu_use_rs2;
    logic [4:0]  alu_op;
    logic        reg_write;
    logic        mem_write;
    logic        mem_read;
    logic [2:0]  mem_op_length;
    logic [3:0]  branch_type;
    logic [4:0]  atomic_op;
    logic        is_compact;
  } fields_t;

  logic        clk;
  logic        reset;
  logic        fetch_valid;
  fetch_word_t fetch_word;
  logic        fetch_ready;
  logic        out_ready;
  logic        out_valid;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [4:0]  rd;
  logic [31:0] immediate;
  logic        alu_use_rs2;
  logic [4:0]  alu_op;
  logic        reg_write;
  logic        mem_write;
  logic        mem_read;
  logic [2:0]  mem_op_length;
  logic [3:0]  branch_type;
  logic [4:0]  atomic_op;
  logic        is_compact;

  logic [31:0] expected [$];
  logic [31:0] rng;
  logic [31:0] stall_state;
  logic [31:0] cur_instr;
  logic        stall_mode;
  int          stall_left;
  int          cycles;
  int          check_count;
  int          error_count;
  int          test_checks;
  int          test_errors;
  int          full_seen;

  decode_top UUT (.*);

  initial clk = 1'b0;
  always #half_period clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [15:0] compact_half(input logic [15:0] r);
    logic [15:0] h;
    h = r;
    if (h[1:0] == 2'b11) h[1:0] = 2'b10; // Low bits 11 would mean a full instruction
    if (h == 16'h0000) h = 16'h0001;
    return h;
  endfunction

  // Expected control fields from the ISA encoding rules
  function automatic fields_t decode_ref(input logic [31:0] ins);
    fields_t f;
    logic [2:0] f3;
    f3 = ins[14:12];
    f = '0;
    f.mem_op_length = f3;
    f.branch_type = branch_none;
    f.atomic_op = atomic_no_op;
    if (ins[1:0] != 2'b11 && ins != 32'h0) begin
      f.is_compact = 1'b1;
      f.rs1 = ins[11:7];
      f.rs2 = ins[6:2];
      f.rd = ins[11:7];
      f.reg_write = 1'b1;
      f.alu_use_rs2 = 1'b1;
      f.alu_op = alu_add_op;
      return f;
    end
    f.rs1 = ins[19:15];
    f.rs2 = ins[24:20];
    f.rd = ins[11:7];
    f.immediate = {{20{ins[31]}}, ins[31:20]}; // I-type unless the opcode says otherwise
    f.alu_op = {ins[25], ins[30], f3};
    case (ins[6:0])
      load_op: begin
        f.reg_write = 1'b1;
        f.mem_read = 1'b1;
        f.alu_op = alu_add_op;
      end
      store_op: begin
        f.mem_write = 1'b1;
        f.alu_op = alu_add_op;
        f.immediate = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      end
      imm_op: begin
        f.reg_write = 1'b1;
        if (f3 == 3'b101) f.immediate = {27'd0, ins[24:20]};
        else f.alu_op = {2'b00, f3};
      end
      reg_op: begin
        f.reg_write = 1'b1;
        f.alu_use_rs2 = 1'b1;
      end
      branch_op: begin
        f.branch_type = {1'b0, f3};
        f.immediate = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      end
      jal_op: begin
        f.reg_write = 1'b1;
        f.branch_type = branch_jal;
        f.immediate = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      jalr_op: begin
        f.reg_write = 1'b1;
        f.branch_type = branch_jalr;
      end
      rv_isa_pkg::atomic_op: begin
        f.reg_write = 1'b1;
        f.mem_read = 1'b1;
        f.mem_write = 1'b1;
        f.alu_op = alu_add_op;
        f.immediate = 32'd0;
        f.atomic_op = ins[31:27];
      end
      default: ;
    endcase
    return f;
  endfunction

  task automatic check_idx(input string what, input logic [4:0] got, input logic [4:0] want);
    check_count++;
    if (got !== want) begin
      error_count++;
      $display("[FAIL] %0t: %s of %h is %h, expected %h", $time, what, cur_instr, got, want);
    end
  endtask

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] want);
    check_count++;
    if (got !== want) begin
      error_count++;
      $display("[FAIL] %0t: %s of %h is %h, expected %h", $time, what, cur_instr, got, want);
    end
  endtask

  task automatic check_code(input string what, input logic [3:0] got, input logic [3:0] want);
    check_count++;
    if (got !== want) begin
      error_count++;
      $display("[FAIL] %0t: %s of %h is %h, expected %h", $time, what, cur_instr, got, want);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic want);
    check_count++;
    if (got !== want) begin
      error_count++;
      $display("[FAIL] %0t: %s of %h is %b, expected %b", $time, what, cur_instr, got, want);
    end
  endtask

  task automatic compare_fields(input logic [31:0] ins);
    fields_t f;
    f = decode_ref(ins);
    cur_instr = ins;
    check_idx("rs1", rs1, f.rs1);
    check_idx("rs2", rs2, f.rs2);
    check_idx("rd", rd, f.rd);
    check_word("immediate", immediate, f.immediate);
    check_flag("alu_use_rs2", alu_use_rs2, f.alu_use_rs2);
    check_idx("alu_op", alu_op, f.alu_op);
    check_flag("reg_write", reg_write, f.reg_write);
    check_flag("mem_write", mem_write, f.mem_write);
    check_flag("mem_read", mem_read, f.mem_read);
    check_code("mem_op_length", {1'b0, mem_op_length}, {1'b0, f.mem_op_length});
    check_code("branch_type", branch_type, f.branch_type);
    check_idx("atomic_op", atomic_op, f.atomic_op);
    check_flag("is_compact", is_compact, f.is_compact);
  endtask

  // Splitting rule applied to an accepted fetch word
  task automatic queue_word(input fetch_word_t fw);
    if (fw.half[0][1:0] == 2'b11) begin
      expected.push_back(fw.full);
    end else begin
      expected.push_back({16'h0000, fw.half[0]});
      if (fw.half[1] != 16'h0000) expected.push_back({16'h0000, fw.half[1]});
    end
  endtask

  task automatic next_random_word(output logic [31:0] w);
    rng = xorshift(rng);
    if (rng[0]) begin
      w = {rng[31:7], class_ops[rng[3:1]]};
    end else begin
      rng = xorshift(rng);
      w[15:0] = compact_half(rng[15:0]);
      w[31:16] = rng[2] ? 16'h0000 : compact_half(rng[31:16]);
    end
  endtask

  // Called on a falling edge and returns on the falling edge after acceptance
  task automatic send_word(input logic [31:0] w);
    logic done;
    done = 1'b0;
    fetch_valid = 1'b1;
    fetch_word.full = w;
    while (!done) begin
      #(half_period - 1);
      done = fetch_ready;
      @(negedge clk);
    end
    fetch_valid = 1'b0;
  endtask

  task automatic drain();
    while (expected.size() != 0 || out_valid) @(negedge clk);
  endtask

  task automatic report_test(input string name);
    $display("test %-16s %0d checks, %0d errors", name, check_count - test_checks,
             error_count - test_errors);
    test_checks = check_count;
    test_errors = error_count;
  endtask

  // Samples just before each rising edge, when everything is settled
  always @(negedge clk) begin
    #(half_period - 1);
    if (!reset) begin
      if (fetch_valid && fetch_ready) queue_word(fetch_word);
      if (out_valid && out_ready) begin
        if (expected.size() == 0) begin
          error_count++;
          $display("Result at %0t arrived with no instruction waiting for it", $time);
        end else begin
          compare_fields(expected.pop_front());
        end
      end
      if (UUT.u_instr_buffer.count == credit_width'(buffer_depth)) begin
        full_seen++;
        cur_instr = 32'h0;
        check_flag("fetch_ready while full", fetch_ready, 1'b0);
      end
    end
  end

  always @(negedge clk) begin
    if (!stall_mode) begin
      out_ready = 1'b1;
    end else if (stall_left > 0) begin
      stall_left--;
    end else begin
      stall_state = xorshift(stall_state);
      out_ready = !out_ready;
      stall_left = out_ready ? int'(stall_state[2:0]) : 8 + int'(stall_state[4:0]);
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("Run stopped after %0d cycles without finishing", timeout_cycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    logic [31:0] w;
    reset = 1'b1;
    fetch_valid = 1'b0;
    fetch_word = '0;
    out_ready = 1'b1;
    stall_mode = 1'b0;
    stall_left = 0;
    rng = 32'd48;
    stall_state = 32'd48;
    cur_instr = 32'h0;
    cycles = 0;
    check_count = 0;
    error_count = 0;
    test_checks = 0;
    test_errors = 0;
    full_seen = 0;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    #(half_period - 1);
    check_flag("out_valid after reset", out_valid, 1'b0);
    check_flag("fetch_ready after reset", fetch_ready, 1'b1);
    report_test("reset");
    @(negedge clk);
    foreach (directed_words[i]) send_word(directed_words[i]);
    drain();
    report_test("directed");
    foreach (compact_words[i]) send_word(compact_words[i]);
    drain();
    report_test("compact");
    for (int n = 0; n < random_count; n++) begin
      next_random_word(w);
      send_word(w);
    end
    drain();
    report_test("random stream");
    rng = 32'd48; // Replay the same stream under back-pressure
    full_seen = 0;
    stall_mode = 1'b1;
    for (int n = 0; n < random_count; n++) begin
      next_random_word(w);
      send_word(w);
    end
    stall_mode = 1'b0;
    drain();
    if (full_seen == 0) begin
      error_count++;
      $display("The buffer never filled while the output was stalled");
    end
    report_test("stalled stream");
    $display("total: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
design/rv_isa_pkg.sv
design/flow_pkg.sv
design/fetch_unit.sv
design/instr_buffer.sv
design/decoder.sv
design/decode_stage.sv
design/decode_top.sv
tests/decode_properties.sv
tests/tb_decode_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f project.f --top-module tb_decode_top \
    -o tb_decode_top \
  && ./obj_dir/tb_decode_top | tee /dev/stderr | grep -qx "=== PASS ===" \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed"; exit 1; }
